// File: udp_echo_pkg.sv
package udp_echo_pkg;

    // Station identity
    localparam logic [47:0] STATION_MAC   = 48'hDEAD_BEEF_000A;
    localparam logic [31:0] STATION_IP    = 32'h10_00_00_00;

    // Fixed header values
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;   // IPv4, five words
    localparam logic [7:0]  REPLY_TTL     = 8'h40;
    localparam logic [15:0] IP_HDR_BYTES  = 16'd20;

    // 14 Ethernet bytes plus 20 IPv4 bytes
    localparam int HDR_BYTES = 34;

    // Byte offsets into the frame, field end where a field spans several bytes
    localparam int ETH_DST_END   = 5;
    localparam int ETH_SRC_END   = 11;
    localparam int ETH_TYPE_END  = 13;
    localparam int IP_VER_OFF    = 14;
    localparam int IP_LEN_END    = 17;
    localparam int IP_PROTO_OFF  = 23;
    localparam int IP_SRC_END    = 29;
    localparam int IP_DST_END    = 33;

    // Buffering
    localparam int PAYLOAD_DEPTH = 2048;
    localparam int HDR_DEPTH     = 4;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    // One entry per accepted frame
    typedef struct packed {
        logic [47:0] mac;   // Sender MAC
        logic [31:0] ip;    // Sender IP
        logic [15:0] len;   // Payload bytes kept
    } rx_hdr_t;

    // Ones'-complement sum over ten header words, checksum word given as zero
    function automatic logic [15:0] ip_checksum(input logic [159:0] hdr);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {16'h0, hdr[16*i +: 16]};
        end
        // Two folds cover any carry out of the first
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        return ~sum[15:0];
    endfunction

endpackage

// File: stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_wr,
    input  T     i_wr_data,
    input  logic i_rd,
    output T     o_rd_data,
    output logic o_full,
    output logic o_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    assign o_full    = (count == (AW+1)'(DEPTH));
    assign o_empty   = (count == '0);
    assign o_rd_data = mem[rd_ptr];   // Head entry, valid when not empty

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: eth_ip_rx_parser.sv
`timescale 1ns/10ps

module eth_ip_rx_parser (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_rx_valid,
    input  udp_echo_pkg::byte_beat_t i_rx_beat,
    input  logic                    i_pay_full,
    input  logic                    i_hdr_full,
    output logic                    o_rx_ready,
    output logic                    o_pay_wr,
    output udp_echo_pkg::byte_beat_t o_pay_beat,
    output logic                    o_hdr_wr,
    output udp_echo_pkg::rx_hdr_t    o_hdr,
    output logic                    o_bad_frame
);

    import udp_echo_pkg::*;

    localparam int CW = $clog2(HDR_BYTES);

    typedef enum logic [1:0] {ST_HDR, ST_PAY, ST_DISC, ST_FIN} state_t;

    state_t        state_q;
    logic [CW-1:0] cnt_q;        // Header byte index
    logic          hdr_ok_q;     // All checks so far passed
    logic          disc_good_q;  // Discarding padding of an accepted frame
    logic [15:0]   kept_q;
    logic          bad_q;

    logic [39:0]   win;          // Last five header bytes
    logic [47:0]   win48;        // Window including current byte
    logic [47:0]   src_mac;
    logic [31:0]   src_ip;
    logic [15:0]   tot_len;
    logic [15:0]   pay_len;

    logic          rx_fire;
    logic          hdr_phase;
    logic          chk;
    logic          hdr_ok_d;
    logic          pay_end;

    assign win48     = {win, i_rx_beat.data};
    assign hdr_phase = (state_q == ST_HDR) || (state_q == ST_FIN);
    assign rx_fire   = i_rx_valid && o_rx_ready;
    assign pay_len   = tot_len - IP_HDR_BYTES;
    assign pay_end   = (kept_q + 16'd1 == pay_len);

    // Stall only on a full FIFO
    always_comb begin
        case (state_q)
            ST_PAY:  o_rx_ready = !i_pay_full;
            ST_FIN:  o_rx_ready = !i_hdr_full;
            default: o_rx_ready = 1'b1;
        endcase
    end

    // Per-byte acceptance check, decided at each field's last byte
    always_comb begin
        chk = 1'b1;
        case (cnt_q)
            CW'(ETH_DST_END):  chk = (win48 == STATION_MAC) || (&win48);
            CW'(ETH_TYPE_END): chk = (win48[15:0] == ETH_TYPE_IPV4);
            CW'(IP_VER_OFF):   chk = (i_rx_beat.data == IP_VER_IHL);
            CW'(IP_PROTO_OFF): chk = (i_rx_beat.data == IP_PROTO_UDP);
            CW'(IP_DST_END):   chk = (win48[31:0] == STATION_IP) && (tot_len > IP_HDR_BYTES);
            default:           chk = 1'b1;
        endcase
    end

    assign hdr_ok_d = ((cnt_q == '0) ? 1'b1 : hdr_ok_q) && chk;

    assign o_pay_wr        = rx_fire && (state_q == ST_PAY);
    assign o_pay_beat.data = i_rx_beat.data;
    assign o_pay_beat.last = pay_end || i_rx_beat.last;   // Padding never stored

    assign o_hdr_wr    = (state_q == ST_FIN) && !i_hdr_full;
    assign o_hdr.mac   = src_mac;
    assign o_hdr.ip    = src_ip;
    assign o_hdr.len   = kept_q;
    assign o_bad_frame = bad_q;

    // Field capture, untouched by byte 0 of a following frame
    always_ff @(posedge i_clk) begin
        if (rx_fire && hdr_phase) begin
            win <= win48[39:0];
            if (cnt_q == CW'(ETH_SRC_END)) src_mac <= win48;
            if (cnt_q == CW'(IP_LEN_END))  tot_len <= win48[15:0];
            if (cnt_q == CW'(IP_SRC_END))  src_ip  <= win48[31:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= ST_HDR;
            cnt_q       <= '0;
            hdr_ok_q    <= 1'b0;
            disc_good_q <= 1'b0;
            kept_q      <= '0;
            bad_q       <= 1'b0;
        end else begin
            bad_q <= 1'b0;
            if (o_hdr_wr) begin
                state_q <= ST_HDR;   // Next frame may start this same cycle
                kept_q  <= '0;
            end
            if (rx_fire) begin
                case (state_q)
                    ST_HDR, ST_FIN: begin
                        hdr_ok_q <= hdr_ok_d;
                        if (i_rx_beat.last) begin
                            cnt_q <= '0;   // Ended inside the header
                            bad_q <= 1'b1;
                        end else if (cnt_q == CW'(HDR_BYTES - 1)) begin
                            cnt_q       <= '0;
                            disc_good_q <= 1'b0;
                            state_q     <= hdr_ok_d ? ST_PAY : ST_DISC;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    ST_PAY: begin
                        kept_q <= kept_q + 16'd1;
                        if (i_rx_beat.last) begin
                            state_q <= ST_FIN;
                        end else if (pay_end) begin
                            state_q     <= ST_DISC;   // Drop padding
                            disc_good_q <= 1'b1;
                        end
                    end
                    default: begin
                        if (i_rx_beat.last) begin
                            if (disc_good_q) begin
                                state_q <= ST_FIN;
                            end else begin
                                state_q <= ST_HDR;
                                bad_q   <= 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

// File: ip_reply_framer.sv
`timescale 1ns/10ps

module ip_reply_framer (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  udp_echo_pkg::rx_hdr_t    i_hdr,
    input  logic                    i_hdr_empty,
    input  udp_echo_pkg::byte_beat_t i_pay_beat,
    input  logic                    i_pay_empty,
    input  logic                    i_tx_ready,
    output logic                    o_hdr_rd,
    output logic                    o_pay_rd,
    output logic                    o_tx_valid,
    output udp_echo_pkg::byte_beat_t o_tx_beat
);

    import udp_echo_pkg::*;

    localparam int IW = $clog2(HDR_BYTES);

    typedef enum logic [1:0] {FR_IDLE, FR_HDR, FR_PAY} fr_state_t;

    fr_state_t     state_q;
    logic [IW-1:0] idx_q;

    // Reply fields held for the whole reply
    logic [47:0]   dst_mac_q;
    logic [31:0]   dst_ip_q;
    logic [15:0]   tot_len_q;
    logic [15:0]   csum_q;

    logic [15:0]   tot_len_d;
    logic [15:0]   csum_d;
    logic [0:HDR_BYTES-1][7:0] reply_hdr;   // Byte 0 leaves first
    logic          hdr_fire;
    logic          pay_fire;

    assign tot_len_d = i_hdr.len + IP_HDR_BYTES;

    // Checksum over the reply's IPv4 header with its checksum word zero
    assign csum_d = ip_checksum({IP_VER_IHL, 8'h00, tot_len_d,
                                 16'h0000, 16'h0000,
                                 REPLY_TTL, IP_PROTO_UDP, 16'h0000,
                                 STATION_IP, i_hdr.ip});

    assign reply_hdr = {dst_mac_q, STATION_MAC, ETH_TYPE_IPV4,
                        IP_VER_IHL, 8'h00, tot_len_q,
                        16'h0000, 16'h0000,
                        REPLY_TTL, IP_PROTO_UDP, csum_q,
                        STATION_IP, dst_ip_q};

    always_comb begin
        case (state_q)
            FR_HDR: begin
                o_tx_valid     = 1'b1;
                o_tx_beat.data = reply_hdr[idx_q];
                o_tx_beat.last = 1'b0;
            end
            FR_PAY: begin
                o_tx_valid = !i_pay_empty;
                o_tx_beat  = i_pay_beat;   // FIFO head holds still until popped
            end
            default: begin
                o_tx_valid = 1'b0;
                o_tx_beat  = i_pay_beat;
            end
        endcase
    end

    assign hdr_fire = (state_q == FR_HDR) && i_tx_ready;
    assign pay_fire = (state_q == FR_PAY) && i_tx_ready && !i_pay_empty;
    assign o_pay_rd = pay_fire;
    assign o_hdr_rd = pay_fire && i_pay_beat.last;   // Header leaves with the final byte

    always_ff @(posedge i_clk) begin
        if (state_q == FR_IDLE && !i_hdr_empty) begin
            dst_mac_q <= i_hdr.mac;
            dst_ip_q  <= i_hdr.ip;
            tot_len_q <= tot_len_d;
            csum_q    <= csum_d;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= FR_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                FR_IDLE: begin
                    if (!i_hdr_empty) begin
                        state_q <= FR_HDR;
                        idx_q   <= '0;
                    end
                end
                FR_HDR: begin
                    if (hdr_fire) begin
                        if (idx_q == IW'(HDR_BYTES - 1)) begin
                            state_q <= FR_PAY;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                default: begin
                    if (o_hdr_rd) begin
                        state_q <= FR_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: udp_echo_top.sv
`timescale 1ns/10ps

module udp_echo_top (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_rx_valid,
    input  udp_echo_pkg::byte_beat_t i_rx_beat,
    input  logic                    i_tx_ready,
    output logic                    o_rx_ready,
    output logic                    o_tx_valid,
    output udp_echo_pkg::byte_beat_t o_tx_beat,
    output logic                    o_bad_frame
);

    import udp_echo_pkg::*;

    // Parser to FIFOs
    logic       pay_wr;
    byte_beat_t pay_wr_beat;
    logic       hdr_wr;
    rx_hdr_t    hdr_wr_data;

    // FIFOs to framer
    logic       pay_rd;
    byte_beat_t pay_rd_beat;
    logic       pay_full;
    logic       pay_empty;
    logic       hdr_rd;
    rx_hdr_t    hdr_rd_data;
    logic       hdr_full;
    logic       hdr_empty;

    eth_ip_rx_parser parser_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_rx_valid  (i_rx_valid),
        .i_rx_beat   (i_rx_beat),
        .i_pay_full  (pay_full),
        .i_hdr_full  (hdr_full),
        .o_rx_ready  (o_rx_ready),
        .o_pay_wr    (pay_wr),
        .o_pay_beat  (pay_wr_beat),
        .o_hdr_wr    (hdr_wr),
        .o_hdr       (hdr_wr_data),
        .o_bad_frame (o_bad_frame)
    );

    stream_fifo #(.T(byte_beat_t), .DEPTH(PAYLOAD_DEPTH)) pay_fifo_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wr      (pay_wr),
        .i_wr_data (pay_wr_beat),
        .i_rd      (pay_rd),
        .o_rd_data (pay_rd_beat),
        .o_full    (pay_full),
        .o_empty   (pay_empty)
    );

    stream_fifo #(.T(rx_hdr_t), .DEPTH(HDR_DEPTH)) hdr_fifo_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wr      (hdr_wr),
        .i_wr_data (hdr_wr_data),
        .i_rd      (hdr_rd),
        .o_rd_data (hdr_rd_data),
        .o_full    (hdr_full),
        .o_empty   (hdr_empty)
    );

    ip_reply_framer framer_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_hdr       (hdr_rd_data),
        .i_hdr_empty (hdr_empty),
        .i_pay_beat  (pay_rd_beat),
        .i_pay_empty (pay_empty),
        .i_tx_ready  (i_tx_ready),
        .o_hdr_rd    (hdr_rd),
        .o_pay_rd    (pay_rd),
        .o_tx_valid  (o_tx_valid),
        .o_tx_beat   (o_tx_beat)
    );

endmodule

// File: udp_echo_chk.sv
`timescale 1ns/10ps

module udp_echo_chk (
    input logic                     i_clk,
    input logic                     i_arst_n,
    input logic                     i_tx_ready,
    input logic                     o_tx_valid,
    input udp_echo_pkg::byte_beat_t o_tx_beat,
    input logic                     o_bad_frame
);

    // Nothing leaves while reset is held
    a_tx_idle_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !o_tx_valid)
        else $error("o_tx_valid high during reset");

    // A stalled beat waits unchanged until taken
    a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_beat))
        else $error("o_tx_beat or o_tx_valid changed while stalled");

    a_bad_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_bad_frame |=> !o_bad_frame)   // One cycle per dropped frame
        else $error("o_bad_frame high for two cycles");

endmodule

bind udp_echo_top udp_echo_chk chk_i (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_tx_ready  (i_tx_ready),
    .o_tx_valid  (o_tx_valid),
    .o_tx_beat   (o_tx_beat),
    .o_bad_frame (o_bad_frame)
);

// File: udp_echo_tb.sv
`timescale 1ns/10ps

module udp_echo_tb;

    import udp_echo_pkg::*;

    localparam int TIMEOUT = 5000;   // Cycles per wait

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        rx_valid = 1'b0;
    byte_beat_t  rx_beat = '0;
    logic        tx_ready = 1'b0;
    logic        rx_ready;
    logic        tx_valid;
    byte_beat_t  tx_beat;
    logic        bad_frame;

    integer      rx_seed = 32'h8c50;
    integer      tx_seed = 32'h8c50;
    logic [31:0] tx_rnd;
    logic [8:0]  exp_q [$];        // Expected reply beats as {data, last}
    int          bad_count = 0;
    int          bad_sent = 0;
    bit          gaps = 1'b0;      // Random valid gaps on receive
    bit          hold_tx = 1'b0;   // Long transmit stall
    bit          rx_low_seen = 1'b0;
    int          idx = 0;          // Byte index in the current reply
    logic [31:0] hsum = '0;
    logic [31:0] rlen = '0;

    udp_echo_top dut_i (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_rx_valid  (rx_valid),
        .i_rx_beat   (rx_beat),
        .i_tx_ready  (tx_ready),
        .o_rx_ready  (rx_ready),
        .o_tx_valid  (tx_valid),
        .o_tx_beat   (tx_beat),
        .o_bad_frame (bad_frame)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic send_byte(input logic [7:0] d, input logic l);
        int t;
        t = 0;
        @(negedge clk);
        if (gaps && ($random(rx_seed) % 4 == 0)) begin
            rx_valid = 1'b0;
            @(negedge clk);
        end
        rx_valid = 1'b1;
        rx_beat  = {d, l};
        @(posedge clk);
        while (!rx_ready) begin
            t = t + 1;
            if (t > TIMEOUT) begin
                abort_run("Timeout waiting for o_rx_ready");
            end
            @(posedge clk);
        end
    endtask

    // One frame out with its reply (if any) queued first
    task automatic send_frame(input logic [47:0] dmac, input logic [15:0] etype,
                              input logic [7:0] vihl, input logic [7:0] proto,
                              input logic [31:0] dip, input int n, input int pad,
                              input int cut, input bit good);
        logic [47:0]  smac;
        logic [31:0]  sip;
        logic [159:0] ip;
        logic [271:0] hb;
        logic [16:0]  acc;
        logic [7:0]   pay [$];
        int           len;
        int           k;
        int           t;
        smac = {16'h0200, 32'($random(rx_seed))};
        sip  = $random(rx_seed);
        len  = (cut > 0) ? cut : n + pad;
        k    = (cut > 0) ? cut : n;   // Bytes the responder keeps
        for (int i = 0; i < len; i++) begin
            pay.push_back(8'($random(rx_seed)));
        end
        if (good) begin
            ip  = {IP_VER_IHL, 8'h00, 16'(20 + k), 32'h0, REPLY_TTL, IP_PROTO_UDP, 16'h0,
                   STATION_IP, sip};
            acc = '0;
            for (int i = 0; i < 10; i++) begin   // End-around carry per word
                acc = {1'b0, acc[15:0]} + {1'b0, ip[16*i +: 16]} + {16'h0, acc[16]};
            end
            while (acc[16]) begin
                acc = {1'b0, acc[15:0]} + {16'h0, acc[16]};
            end
            ip[79:64] = ~acc[15:0];   // Checksum word
            hb = {smac, STATION_MAC, ETH_TYPE_IPV4, ip};
            for (int i = 0; i < 34; i++) begin
                exp_q.push_back({hb[271-8*i -: 8], 1'b0});
            end
            for (int i = 0; i < k; i++) begin
                exp_q.push_back({pay[i], i == k - 1});
            end
        end
        hb = {dmac, smac, etype, vihl, 8'h00, 16'(20 + n), 32'h0, 8'h80, proto, 16'h0,
              sip, dip};
        for (int i = 0; i < 34; i++) begin
            send_byte(hb[271-8*i -: 8], 1'b0);
        end
        for (int i = 0; i < len; i++) begin
            send_byte(pay[i], i == len - 1);
        end
        @(negedge clk);
        rx_valid = 1'b0;
        if (!good) begin
            bad_sent = bad_sent + 1;
            t = 0;
            while (bad_count != bad_sent) begin
                @(posedge clk);
                t = t + 1;
                if (t > TIMEOUT) begin
                    abort_run("Timeout waiting for the o_bad_frame pulse");
                end
            end
        end
    endtask

    task automatic send_udp(input int n, input int pad, input int cut);
        send_frame(STATION_MAC, ETH_TYPE_IPV4, IP_VER_IHL, IP_PROTO_UDP, STATION_IP,
                   n, pad, cut, 1'b1);
    endtask

    // Random ready that is held low through a long stall until the receive side backs up
    always @(negedge clk) begin
        if (hold_tx && !rx_ready) begin
            rx_low_seen = 1'b1;
        end
        tx_rnd   = $random(tx_seed);
        tx_ready = !(hold_tx && !rx_low_seen) && (tx_rnd[1:0] != 2'b00);
    end

    always @(posedge clk) begin
        if (bad_frame) begin
            bad_count <= bad_count + 1;
        end
    end

    always @(posedge clk) begin
        if (arst_n && tx_valid && tx_ready) begin
            assert (exp_q.size() > 0) else abort_run("Reply byte seen with no reply pending");
            assert (tx_beat == exp_q[0])
                else abort_run($sformatf("Mismatch at %0t: reply byte %0d is %h, expected %h",
                                         $time, idx, tx_beat, exp_q[0]));
            void'(exp_q.pop_front());
            if (idx >= 14 && idx <= 33) begin   // IPv4 header words
                hsum = hsum + (idx[0] ? {24'h0, tx_beat.data} : {16'h0, tx_beat.data, 8'h0});
            end
            if (idx == 16 || idx == 17) begin
                rlen = {rlen[23:0], tx_beat.data};
            end
            if (idx == 33) begin
                hsum = {16'h0, hsum[15:0]} + {16'h0, hsum[31:16]};
                hsum = {16'h0, hsum[15:0]} + {16'h0, hsum[31:16]};
                assert (hsum[15:0] == 16'hFFFF)
                    else abort_run($sformatf("Mismatch at %0t: IPv4 header sum %h",
                                             $time, hsum[15:0]));
            end
            if (tx_beat.last) begin
                assert (rlen == 32'(idx - 13))
                    else abort_run($sformatf("Mismatch at %0t: total length %0d, %0d bytes",
                                             $time, rlen, idx - 33));
                idx  = 0;
                hsum = '0;
                rlen = '0;
            end else begin
                idx = idx + 1;
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          t;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        send_udp(18, 0, 0);
        // One wrong field per frame
        send_frame(48'h0200_0000_0001, ETH_TYPE_IPV4, IP_VER_IHL, IP_PROTO_UDP, STATION_IP,
                   8, 0, 0, 1'b0);
        send_frame(STATION_MAC, 16'h0806, IP_VER_IHL, IP_PROTO_UDP, STATION_IP,
                   8, 0, 0, 1'b0);
        send_frame(STATION_MAC, ETH_TYPE_IPV4, 8'h46, IP_PROTO_UDP, STATION_IP,
                   8, 0, 0, 1'b0);
        send_frame(STATION_MAC, ETH_TYPE_IPV4, IP_VER_IHL, 8'h06, STATION_IP,
                   8, 0, 0, 1'b0);
        send_frame(STATION_MAC, ETH_TYPE_IPV4, IP_VER_IHL, IP_PROTO_UDP, STATION_IP ^ 32'h1,
                   8, 0, 0, 1'b0);
        send_frame(48'hFFFF_FFFF_FFFF, ETH_TYPE_IPV4, IP_VER_IHL, IP_PROTO_UDP, STATION_IP,
                   12, 0, 0, 1'b1);
        send_udp(6, 12, 0);   // Ethernet padding
        send_udp(40, 0, 9);   // Ends inside the payload
        gaps = 1'b1;
        for (int i = 0; i < 8; i++) begin
            r = $random(rx_seed);
            send_udp(1 + int'(r[5:0]), int'(r[9:8]), 0);
        end
        hold_tx = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send_udp(30, 0, 0);
        end
        assert (rx_low_seen) else abort_run("o_rx_ready never fell during the long stall");
        t = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            t = t + 1;
            if (t > TIMEOUT) begin
                abort_run("Timeout waiting for the remaining reply bytes");
            end
        end
        if (bad_count == bad_sent) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run($sformatf("Mismatch at %0t: %0d o_bad_frame pulses, expected %0d",
                                $time, bad_count, bad_sent));
        end
    end

endmodule

// File: udp_echo.f
udp_echo_pkg.sv
stream_fifo.sv
eth_ip_rx_parser.sv
ip_reply_framer.sv
udp_echo_top.sv
udp_echo_chk.sv
udp_echo_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := udp_echo_tb
FLIST     := udp_echo.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "** FAIL **" >> $(LOG)
	@cat $(LOG)
	@! grep -q "\*\* FAIL \*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
